// ==== hw/lvd_defines.svh ====
/*
  conditioning word layout, SPI register map and mode codes.
  register addresses are 7 bits, bit 7 of the SPI address byte flags a read.
*/
`ifndef LVD_DEFINES_SVH
`define LVD_DEFINES_SVH

// bus widths
`define LVD_REG_W   32  // every SPI register
`define LVD_ADDR_W  8   // address byte at the start of a frame
`define LVD_COND_W  29  // conditioning word driven to the pins

////////////////////////////////////////
// bit offsets in the conditioning word
`define LVD_IDX_AZMUX          0   // 4 bits, azmux select and enable
`define LVD_IDX_HIMUX          4   // 4 bits
`define LVD_IDX_HIMUX2         8   // 4 bits
`define LVD_IDX_PC_SW          12  // pre-charge switch
`define LVD_IDX_LED0           13
`define LVD_IDX_MONITOR        14  // 8 monitor pins
`define LVD_IDX_ADCMUX         22  // 4 adc current switches
`define LVD_IDX_CMPR_LATCH     26
`define LVD_IDX_MEAS_COMPLETE  27
`define LVD_IDX_SPI_INT        28  // top bit

////////////////////////////////////////
// register addresses
`define LVD_REG_LED         7   // bit 0 only
`define LVD_REG_MODE        8   // bits 2..0
`define LVD_REG_DIRECT      9   // direct word, azmux lo value in az mode
`define LVD_REG_DIRECT2     10  // azmux hi value in bits 3..0
`define LVD_REG_SAMPLE_DUR  11  // az phase length in clk, 0 acts as 1

// mode codes, 5 to 7 drive all zero
`define LVD_MODE_IDLE     0
`define LVD_MODE_ONES     1
`define LVD_MODE_PATTERN  2
`define LVD_MODE_DIRECT   3
`define LVD_MODE_AZ       4

`endif

// ==== hw/lvd_pkg.sv ====
/*
  types of the 29-bit conditioning word.
  field widths come from the offsets in the defines header, so the union
  members stay the same size as long as the offsets are ascending.
*/
`include "lvd_defines.svh"

package lvd_pkg;

  ////////////////////////////////////////
  // fields, msb first
  typedef struct packed {
    logic [`LVD_COND_W-`LVD_IDX_SPI_INT-1:0]               spi_int;       // mcu interrupt
    logic [`LVD_IDX_SPI_INT-`LVD_IDX_MEAS_COMPLETE-1:0]    meas_complete;
    logic [`LVD_IDX_MEAS_COMPLETE-`LVD_IDX_CMPR_LATCH-1:0] cmpr_latch;
    logic [`LVD_IDX_CMPR_LATCH-`LVD_IDX_ADCMUX-1:0]        adcmux;        // current switches
    logic [`LVD_IDX_ADCMUX-`LVD_IDX_MONITOR-1:0]           monitor;
    logic [`LVD_IDX_MONITOR-`LVD_IDX_LED0-1:0]             led0;
    logic [`LVD_IDX_LED0-`LVD_IDX_PC_SW-1:0]               pc_sw;         // pre-charge
    logic [`LVD_IDX_PC_SW-`LVD_IDX_HIMUX2-1:0]             himux2;
    logic [`LVD_IDX_HIMUX2-`LVD_IDX_HIMUX-1:0]             himux;
    logic [`LVD_IDX_HIMUX-`LVD_IDX_AZMUX-1:0]              azmux;         // lsb nibble
  } cond_fields_t;

  ////////////////////////////////////////
  // one word, two views
  // flat for register and counter sources, fld for per-switch work
  typedef union packed {
    logic [`LVD_COND_W-1:0] flat;
    cond_fields_t           fld;
  } cond_word_t;

endpackage

// ==== hw/spi_reg_bank.sv ====
/*
  SPI slave, mode 0, oversampled on clk. spi_sck must stay below clk/8.
  frame is 8 address bits then 32 data bits, msb first, addr bit 7 = read.
  a write commits on the chip select rise only if exactly 40 bits came in.
  registers update 3 to 5 clk after the chip select rise.
*/
`timescale 1ns/1ps
`include "lvd_defines.svh"

module spi_reg_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  spi_sck,
  input  logic                  spi_cs_n,
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  output logic                  reg_led,
  output logic [2:0]            reg_mode,
  output logic [`LVD_REG_W-1:0] reg_direct,
  output logic [`LVD_REG_W-1:0] reg_direct2,
  output logic [`LVD_REG_W-1:0] reg_sample_dur
);

  localparam int FRAME_BITS = `LVD_ADDR_W + `LVD_REG_W;  // 40
  localparam int CNT_W      = $clog2(FRAME_BITS) + 1;    // room to saturate past 40

  logic [2:0]                  sck_sr;    // [1] synced, [2] previous
  logic [2:0]                  cs_sr;
  logic [1:0]                  mosi_sr;
  logic                        sck_rise;
  logic                        sck_fall;
  logic                        cs_rise;
  logic                        cs_active;
  logic [FRAME_BITS-1:0]       rx_sr;
  logic [CNT_W-1:0]            bit_cnt;   // bits taken in this frame
  logic [`LVD_REG_W-1:0]       tx_sr;
  logic [`LVD_REG_W-1:0]       rd_data;
  logic [`LVD_ADDR_W-1:0]      rd_addr;
  logic [`LVD_ADDR_W-1:0]      wr_addr;
  logic [`LVD_REG_W-1:0]       wr_data;

  ////////////////////////////////////////
  // synchronisers and edge detect
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sck_sr  <= '0;
      cs_sr   <= '1;  // deselected
      mosi_sr <= '0;
    end
    else
    begin
      sck_sr  <= {sck_sr[1:0], spi_sck};
      cs_sr   <= {cs_sr[1:0], spi_cs_n};
      mosi_sr <= {mosi_sr[0], spi_mosi};  // same delay as sck_sr[1]
    end
  end

  assign sck_rise  = sck_sr[1] & ~sck_sr[2];
  assign sck_fall  = ~sck_sr[1] & sck_sr[2];
  assign cs_rise   = cs_sr[1] & ~cs_sr[2];  // end of frame
  assign cs_active = ~cs_sr[1];

  ////////////////////////////////////////
  // receive side
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (!cs_active)
      bit_cnt <= '0;                        // still read by the commit in the cs_rise cycle
    else if (sck_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;            // saturates so long frames never look like 40
  end

  always_ff @(posedge clk)
  begin
    if (cs_active && sck_rise)
      rx_sr <= {rx_sr[FRAME_BITS-2:0], mosi_sr[1]};
  end

  assign rd_addr = rx_sr[`LVD_ADDR_W-1:0];              // valid once 8 bits are in
  assign wr_addr = rx_sr[FRAME_BITS-1 -: `LVD_ADDR_W];  // valid at 40 bits
  assign wr_data = rx_sr[`LVD_REG_W-1:0];

  // read-back select, unknown or write address gives 0
  always_comb
  begin
    rd_data = '0;
    if (rd_addr[`LVD_ADDR_W-1])
    begin
      case (rd_addr[`LVD_ADDR_W-2:0])
        `LVD_REG_LED:        rd_data = {{(`LVD_REG_W-1){1'b0}}, reg_led};
        `LVD_REG_MODE:       rd_data = {{(`LVD_REG_W-3){1'b0}}, reg_mode};
        `LVD_REG_DIRECT:     rd_data = reg_direct;
        `LVD_REG_DIRECT2:    rd_data = reg_direct2;
        `LVD_REG_SAMPLE_DUR: rd_data = reg_sample_dur;
        default:             rd_data = '0;
      endcase
    end
  end

  ////////////////////////////////////////
  // transmit side, loads on the fall after the address byte
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      tx_sr <= '0;
    else if (!cs_active)
      tx_sr <= '0;                              // keeps miso low between frames
    else if (sck_fall)
    begin
      if (bit_cnt == `LVD_ADDR_W)
        tx_sr <= rd_data;                       // msb out before the 9th rising edge
      else if (bit_cnt > `LVD_ADDR_W)
        tx_sr <= {tx_sr[`LVD_REG_W-2:0], 1'b0};
    end
  end

  assign spi_miso = tx_sr[`LVD_REG_W-1];

  ////////////////////////////////////////
  // register bank
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      reg_led        <= 1'b0;
      reg_mode       <= '0;
      reg_direct     <= '0;
      reg_direct2    <= '0;
      reg_sample_dur <= '0;
    end
    else if (cs_rise && bit_cnt == FRAME_BITS && !wr_addr[`LVD_ADDR_W-1])
    begin
      case (wr_addr[`LVD_ADDR_W-2:0])
        `LVD_REG_LED:        reg_led        <= wr_data[0];
        `LVD_REG_MODE:       reg_mode       <= wr_data[2:0];
        `LVD_REG_DIRECT:     reg_direct     <= wr_data;
        `LVD_REG_DIRECT2:    reg_direct2    <= wr_data;
        `LVD_REG_SAMPLE_DUR: reg_sample_dur <= wr_data;
        default:             ;                  // unknown address, dropped
      endcase
    end
  end

  // select held high long enough to pass the synchroniser clears miso
  miso_idle_a : assert property (@(posedge clk) disable iff (!rst_n)
    spi_cs_n [*4] |=> !spi_miso)
    else $error("spi_miso active while deselected");

endmodule

// ==== hw/az_modulator.sv ====
/*
  auto-zero modulation. hi and lo phases each last sample_dur clk, 0 acts as 1.
  outputs are combinational from the phase state, the mode mux registers them.
  only azmux, pc_sw, led0 and monitor are driven, other fields are 0.
*/
`timescale 1ns/1ps
`include "lvd_defines.svh"

module az_modulator
  import lvd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [3:0]            azmux_hi,    // signal side value
  input  logic [3:0]            azmux_lo,    // zero side value
  input  logic [`LVD_REG_W-1:0] sample_dur,
  output cond_word_t            az_word
);

  localparam logic [`LVD_REG_W-1:0] ONE = 1;

  logic [`LVD_REG_W-1:0] dur_eff;     // duration with 0 mapped to 1
  logic [`LVD_REG_W-1:0] phase_cnt;   // clk spent in the current phase
  logic                  phase_end;
  logic                  phase_hi;    // 1 = hi phase
  logic                  led_q;
  logic [6:0]            cycle_cnt;   // completed hi+lo pairs

  assign dur_eff   = (sample_dur == '0) ? ONE : sample_dur;
  // >= also covers the duration shrinking mid-phase
  assign phase_end = (phase_cnt >= dur_eff - ONE);

  ////////////////////////////////////////
  // phase sequencing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      phase_cnt <= '0;
      phase_hi  <= 1'b1;   // start in hi
      led_q     <= 1'b0;
      cycle_cnt <= '0;
    end
    else if (phase_end)
    begin
      phase_cnt <= '0;
      phase_hi  <= ~phase_hi;
      if (!phase_hi)
      begin
        // lo phase done, closes a full cycle
        led_q     <= ~led_q;
        cycle_cnt <= cycle_cnt + 1'b1;   // wraps at 128
      end
    end
    else
    begin
      phase_cnt <= phase_cnt + ONE;
    end
  end

  ////////////////////////////////////////
  // output word
  always_comb
  begin
    az_word               = '0;
    az_word.fld.azmux     = phase_hi ? azmux_hi : azmux_lo;
    az_word.fld.pc_sw     = phase_hi;            // pre-charge on during hi
    az_word.fld.led0      = led_q;
    az_word.fld.monitor   = {cycle_cnt, phase_hi};  // bit 0 shows the phase
  end

  // a duration held for two cycles bounds the counter
  phase_bound_a : assert property (@(posedge clk) disable iff (!rst_n)
    $stable(sample_dur) |-> phase_cnt < dur_eff)
    else $error("az phase counter reached the sample duration");

endmodule

// ==== hw/output_mode_mux.sv ====
/*
  picks the conditioning word by mode and registers it, pins lag sources 1 clk.
  the test pattern counter free runs in every mode.
  modes 5 to 7 drive all zero.
*/
`timescale 1ns/1ps
`include "lvd_defines.svh"

module output_mode_mux
  import lvd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [2:0] mode,
  input  logic       led_bit,       // led register, used in mode 0
  input  cond_word_t direct_word,
  input  cond_word_t az_word,
  output cond_word_t cond_out
);

  logic [`LVD_COND_W-1:0] test_cnt;   // wraps at 2^29
  cond_word_t             idle_word;
  cond_word_t             az_mode_word;
  cond_word_t             sel_word;

  ////////////////////////////////////////
  // per-mode words
  always_comb
  begin
    idle_word          = '0;
    idle_word.fld.led0 = led_bit;   // everything off but the led
  end

  // direct register for himux, adc and status, modulator for the rest
  always_comb
  begin
    az_mode_word             = direct_word;
    az_mode_word.fld.azmux   = az_word.fld.azmux;
    az_mode_word.fld.pc_sw   = az_word.fld.pc_sw;
    az_mode_word.fld.led0    = az_word.fld.led0;
    az_mode_word.fld.monitor = az_word.fld.monitor;
  end

  always_comb
  begin
    case (mode)
      `LVD_MODE_IDLE:    sel_word = idle_word;
      `LVD_MODE_ONES:    sel_word.flat = '1;
      `LVD_MODE_PATTERN: sel_word.flat = test_cnt;
      `LVD_MODE_DIRECT:  sel_word = direct_word;
      `LVD_MODE_AZ:      sel_word = az_mode_word;
      default:           sel_word = '0;
    endcase
  end

  ////////////////////////////////////////
  // counter and output register
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      test_cnt <= '0;
      cond_out <= '0;
    end
    else
    begin
      test_cnt <= test_cnt + 1'b1;
      cond_out <= sel_word;
    end
  end

  unused_mode_zero_a : assert property (@(posedge clk) disable iff (!rst_n)
    (mode > 3'(`LVD_MODE_AZ)) |=> (cond_out.flat == '0))
    else $error("mode 5..7 left a nonzero word on the pins");

endmodule

// ==== hw/lvd_top.sv ====
/*
  voltmeter front end control. single clock, SPI is oversampled on clk.
  every pin output comes straight from the registered conditioning word.
*/
`timescale 1ns/1ps
`include "lvd_defines.svh"

module lvd_top
  import lvd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // mcu spi
  input  logic       spi_sck,
  input  logic       spi_cs_n,
  input  logic       spi_mosi,
  output logic       spi_miso,
  // conditioning pins
  output logic [3:0] azmux_ctl,
  output logic [3:0] himux_ctl,
  output logic [3:0] himux2_ctl,
  output logic [3:0] adcmux_ctl,    // adc current switches
  output logic [7:0] monitor,
  output logic       sig_pc_sw_ctl,
  output logic       led0,
  output logic       cmpr_latch_ctl,
  output logic       meas_complete_ctl,
  output logic       spi_interrupt_ctl
);

  logic                  reg_led;
  logic [2:0]            reg_mode;
  logic [`LVD_REG_W-1:0] reg_direct;
  logic [`LVD_REG_W-1:0] reg_direct2;
  logic [`LVD_REG_W-1:0] reg_sample_dur;
  cond_word_t            direct_word;
  cond_word_t            az_word;
  cond_word_t            cond_out;

  ////////////////////////////////////////
  // registers and sources
  spi_reg_bank spi_reg_bank_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .spi_sck        (spi_sck),
    .spi_cs_n       (spi_cs_n),
    .spi_mosi       (spi_mosi),
    .spi_miso       (spi_miso),
    .reg_led        (reg_led),
    .reg_mode       (reg_mode),
    .reg_direct     (reg_direct),
    .reg_direct2    (reg_direct2),
    .reg_sample_dur (reg_sample_dur)
  );

  assign direct_word.flat = reg_direct[`LVD_COND_W-1:0];   // top 3 bits unused

  // hi value from direct2, lo value from direct, same nibble position
  az_modulator az_modulator_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .azmux_hi   (reg_direct2[`LVD_IDX_AZMUX +: 4]),
    .azmux_lo   (reg_direct[`LVD_IDX_AZMUX +: 4]),
    .sample_dur (reg_sample_dur),
    .az_word    (az_word)
  );

  output_mode_mux output_mode_mux_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (reg_mode),
    .led_bit     (reg_led),
    .direct_word (direct_word),
    .az_word     (az_word),
    .cond_out    (cond_out)
  );

  ////////////////////////////////////////
  // unpack to pins
  assign azmux_ctl         = cond_out.fld.azmux;
  assign himux_ctl         = cond_out.fld.himux;
  assign himux2_ctl        = cond_out.fld.himux2;
  assign sig_pc_sw_ctl     = cond_out.fld.pc_sw;
  assign led0              = cond_out.fld.led0;
  assign monitor           = cond_out.fld.monitor;
  assign adcmux_ctl        = cond_out.fld.adcmux;
  assign cmpr_latch_ctl    = cond_out.fld.cmpr_latch;
  assign meas_complete_ctl = cond_out.fld.meas_complete;
  assign spi_interrupt_ctl = cond_out.fld.spi_int;

endmodule

// ==== dv/lvd_tb.sv ====
/*
  testbench for lvd_top. SPI is bit-banged at 8 clk per sck period.
  pins are compared every clk while a check window is open.
  the pattern mode is checked by increments, the az mode by phase run lengths.
*/
`timescale 1ns/1ps
`include "lvd_defines.svh"

module lvd_tb;

  localparam logic [6:0] REG_ADDR [5] = '{`LVD_REG_LED, `LVD_REG_MODE, `LVD_REG_DIRECT,
                                          `LVD_REG_DIRECT2, `LVD_REG_SAMPLE_DUR};
  localparam logic [2:0] STATIC_MODES [5] = '{1, 3, 5, 6, 7};

  logic       clk;
  logic       rst_n;
  logic       spi_sck;
  logic       spi_cs_n;
  logic       spi_mosi;
  logic       spi_miso;
  logic [3:0] azmux_ctl;
  logic [3:0] himux_ctl;
  logic [3:0] himux2_ctl;
  logic [3:0] adcmux_ctl;
  logic [7:0] monitor;
  logic       sig_pc_sw_ctl;
  logic       led0;
  logic       cmpr_latch_ctl;
  logic       meas_complete_ctl;
  logic       spi_interrupt_ctl;

  logic [`LVD_COND_W-1:0] pin_word;   // pins packed back in field order

  // check window state driven by the stimulus
  logic                  chk_en      = 1'b0;
  logic [2:0]            chk_mode    = '0;
  logic                  exp_led     = 1'b0;
  logic [`LVD_REG_W-1:0] exp_direct  = '0;
  logic [`LVD_REG_W-1:0] exp_direct2 = '0;
  logic [`LVD_REG_W-1:0] exp_dur     = 1;
  int unsigned           frames_sent = 0;

  // compare process state
  logic [`LVD_COND_W-1:0] exp_word;
  logic [`LVD_COND_W-1:0] prev_word;
  logic                   have_prev = 1'b0;
  logic                   az_init   = 1'b0;
  logic                   cur_phase = 1'b1;   // 1 = hi
  logic                   first_run = 1'b1;   // run in progress when the window opened
  logic                   m_led     = 1'b0;
  logic [6:0]             m_cyc     = '0;
  int unsigned            run_len   = 0;
  int unsigned            az_cycles = 0;      // lo phases completed in this window

  lvd_top lvd_top_i (.*);

  assign pin_word = {spi_interrupt_ctl, meas_complete_ctl, cmpr_latch_ctl, adcmux_ctl, monitor,
                     led0, sig_pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl};

  always #10 clk = ~clk;   // 50 MHz

  ////////////////////////////////////////
  // expected pin word per mode
  function automatic logic [`LVD_COND_W-1:0] ref_word(
    input logic [2:0]  mode,
    input logic        led,
    input logic [31:0] direct,
    input logic [31:0] direct2,
    input logic        phase_hi,
    input logic        az_led,
    input logic [6:0]  az_cyc
  );
    logic [`LVD_COND_W-1:0] w;
    w = '0;
    case (mode)
      `LVD_MODE_IDLE:   w[`LVD_IDX_LED0] = led;
      `LVD_MODE_ONES:   w = '1;
      `LVD_MODE_DIRECT: w = direct[`LVD_COND_W-1:0];
      `LVD_MODE_AZ:
      begin
        w = direct[`LVD_COND_W-1:0];   // himux, adc and status lines pass through
        w[`LVD_IDX_AZMUX +: 4]   = phase_hi ? direct2[3:0] : direct[3:0];
        w[`LVD_IDX_PC_SW]        = phase_hi;
        w[`LVD_IDX_LED0]         = az_led;
        w[`LVD_IDX_MONITOR +: 8] = {az_cyc, phase_hi};
      end
      default:          w = '0;   // 5 to 7
    endcase
    return w;
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_mismatch(
    input string       name,
    input logic [31:0] exp,
    input logic [31:0] act
  );
    $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
    abort_run();
  endtask

  ////////////////////////////////////////
  // mode 0 SPI master shifting msb first
  task automatic shift_frame(
    input  logic [7:0]  addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
  );
    logic [39:0] frame;
    frame = {addr, wdata};
    rdata = '0;
    @(posedge clk);
    spi_cs_n    <= 1'b0;
    frames_sent <= frames_sent + 1;
    for (int i = 39; i >= 0; i--)
    begin
      @(posedge clk);
      spi_sck  <= 1'b0;
      spi_mosi <= frame[i];          // set up in the low half
      repeat (4) @(posedge clk);
      spi_sck <= 1'b1;               // slave samples here
      repeat (2) @(posedge clk);
      if (i < 32)
        rdata[i] = spi_miso;         // mid high half where miso has settled
      @(posedge clk);
    end
    @(posedge clk);
    spi_sck <= 1'b0;
    repeat (4) @(posedge clk);
    spi_cs_n <= 1'b1;
    repeat (10) @(posedge clk);      // commit lands within 5 clk
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    shift_frame({1'b0, addr}, data, ignored);
  endtask

  task automatic check_readback(input logic [6:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    shift_frame({1'b1, addr}, 32'h0, rd);
    assert (rd == exp)
      else report_mismatch($sformatf("spi_miso read of reg %0d", addr), exp, rd);
  endtask

  ////////////////////////////////////////
  // check windows
  task automatic open_check(input logic [2:0] mode);
    @(posedge clk);
    chk_mode <= mode;
    chk_en   <= 1'b1;
  endtask

  task automatic close_check();
    @(posedge clk);
    chk_en <= 1'b0;
  endtask

  task automatic watch_mode(input logic [2:0] mode, input int n);
    open_check(mode);
    repeat (n) @(posedge clk);
    close_check();
  endtask

  // tracks the az phase on monitor bit 0 and steps the led and cycle count
  task follow_az_phase();
    if (!az_init)
    begin
      cur_phase = pin_word[`LVD_IDX_MONITOR];
      m_led     = pin_word[`LVD_IDX_LED0];
      m_cyc     = pin_word[`LVD_IDX_MONITOR+1 +: 7];
      run_len   = 1;
      first_run = 1'b1;
      az_init   = 1'b1;
    end
    else if (pin_word[`LVD_IDX_MONITOR] == cur_phase)
    begin
      run_len++;
      if (!first_run)
        assert (run_len <= exp_dur) else report_mismatch("monitor[0] run", exp_dur, run_len);
    end
    else
    begin
      if (!first_run)
        assert (run_len == exp_dur) else report_mismatch("monitor[0] run", exp_dur, run_len);
      if (!cur_phase)
      begin
        m_led = ~m_led;              // lo phase completed
        m_cyc = m_cyc + 1'b1;
        az_cycles++;
      end
      cur_phase = ~cur_phase;
      run_len   = 1;
      first_run = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // compare process
  always @(posedge clk)
  begin
    if (!chk_en)
    begin
      have_prev = 1'b0;
      az_init   = 1'b0;
      az_cycles = 0;
    end
    else if (chk_mode == `LVD_MODE_PATTERN)
    begin
      exp_word = prev_word + 1'b1;   // wraps at 2^29
      if (have_prev)
        assert (pin_word == exp_word) else report_mismatch("pin_word", exp_word, pin_word);
      prev_word = pin_word;
      have_prev = 1'b1;
    end
    else
    begin
      if (chk_mode == `LVD_MODE_AZ)
        follow_az_phase();
      exp_word = ref_word(chk_mode, exp_led, exp_direct, exp_direct2, cur_phase, m_led, m_cyc);
      assert (pin_word == exp_word) else report_mismatch("pin_word", exp_word, pin_word);
    end
  end

  // budget grows with every SPI frame
  initial
  begin
    int unsigned cycles;
    cycles = 0;
    while (cycles <= 5000 + 400 * frames_sent)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d clk, the run is stuck", cycles);
    abort_run();
  end

  ////////////////////////////////////////
  // stimulus
  initial
  begin
    logic [31:0] wval [5];
    logic [31:0] dur;
    void'($urandom(73773));
    clk      = 1'b0;
    rst_n    = 1'b0;
    spi_sck  = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // reset state then the led alone in mode 0
    watch_mode(`LVD_MODE_IDLE, 20);
    write_reg(`LVD_REG_LED, 32'h1);
    exp_led <= 1'b1;
    watch_mode(`LVD_MODE_IDLE, 20);

    // random writes read back and an unmapped address reads 0
    for (int i = 0; i < 5; i++)
    begin
      wval[i] = $urandom();
      write_reg(REG_ADDR[i], wval[i]);
    end
    check_readback(`LVD_REG_LED, {31'b0, wval[0][0]});
    check_readback(`LVD_REG_MODE, {29'b0, wval[1][2:0]});
    for (int i = 2; i < 5; i++)
      check_readback(REG_ADDR[i], wval[i]);
    check_readback(7'd3, 32'h0);
    exp_led     <= wval[0][0];
    exp_direct  <= wval[2];
    exp_direct2 <= wval[3];

    // ones, direct and the zero modes
    for (int i = 0; i < 5; i++)
    begin
      write_reg(`LVD_REG_MODE, 32'(STATIC_MODES[i]));
      watch_mode(STATIC_MODES[i], 20);
    end

    write_reg(`LVD_REG_MODE, `LVD_MODE_PATTERN);
    watch_mode(`LVD_MODE_PATTERN, 60);

    // az modulation over random durations
    write_reg(`LVD_REG_MODE, `LVD_MODE_AZ);
    for (int k = 0; k < 4; k++)
    begin
      dur = $urandom_range(12, 1);
      write_reg(`LVD_REG_SAMPLE_DUR, dur);
      exp_dur <= dur;
      open_check(`LVD_MODE_AZ);
      wait (az_cycles >= 3);
      close_check();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/lvd_pkg.sv
hw/spi_reg_bank.sv
hw/az_modulator.sv
hw/output_mode_mux.sv
hw/lvd_top.sv
dv/lvd_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds lvd_tb with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module lvd_tb -f project.f -o lvd_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/lvd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
